// File: common/ulpiPkg.sv
// ULPI link package
// Request opcodes, TXCMD prefixes, bus widths, synchronizer depth, engine states
package ulpiPkg;

    localparam int ulpiAddrWidth = 6;  // Immediate register address
    localparam int ulpiDataWidth = 8;  // ULPI data bus and PHY registers
    localparam int syncStages    = 2;  // Receive synchronizer depth

    // TXCMD prefix, bits [7:6] of the command byte
    localparam logic [1:0] regWriteCmd = 2'b10;
    localparam logic [1:0] regReadCmd  = 2'b11;

    // Client request opcode
    typedef enum logic {
        REG_WRITE = 1'b0,
        REG_READ  = 1'b1
    } regOpT;

    // Register-write engine
    typedef enum logic [2:0] {
        W_IDLE = 3'd0,
        W_CMD  = 3'd1,  // TXCMD on bus until NXT
        W_DATA = 3'd2,  // Data byte until NXT
        W_STOP = 3'd3   // Single STP cycle
    } writeStateT;

    // Register-read engine
    typedef enum logic [2:0] {
        R_IDLE    = 3'd0,
        R_CMD     = 3'd1,  // TXCMD on bus until NXT
        R_TURN    = 3'd2,  // Bus released, waiting for DIR
        R_CAPTURE = 3'd3,  // Waiting for synchronized byte
        R_RELEASE = 3'd4   // Waiting for DIR to drop
    } readStateT;

endpackage

// File: common/ulpiBus.sv
`timescale 1ns/1ns
// One engine's view of the ULPI pins
// Link modport drives receive side, engine modport drives transmit side
interface ulpiBus;

    logic                               dir;      // PHY owns the bus
    logic                               nxt;      // PHY throttle
    logic [ulpiPkg::ulpiDataWidth-1:0]  rxData;   // Synchronized receive byte
    logic                               rxFresh;  // rxData holds PHY-driven data
    logic [ulpiPkg::ulpiDataWidth-1:0]  txData;   // Zero when engine is idle
    logic                               stp;

    // Link side
    modport link (
        output dir,
        output nxt,
        output rxData,
        output rxFresh,
        input  txData,
        input  stp
    );

    // Engine side
    modport engine (
        input  dir,
        input  nxt,
        input  rxData,
        input  rxFresh,
        output txData,
        output stp
    );

endinterface

// File: verilog/ulpiReqDispatch.sv
`timescale 1ns/1ns
// Request dispatcher with engine start pulses and read response holding
// Merges both engines' outgoing bytes and STP onto the pins
module ulpiReqDispatch (
    input  logic                               clk_ULPI,
    input  logic                               rst,
    input  logic                               reqValid,
    output logic                               reqReady,
    input  ulpiPkg::regOpT                     reqOp,
    input  logic [ulpiPkg::ulpiAddrWidth-1:0]  reqAddr,
    input  logic [ulpiPkg::ulpiDataWidth-1:0]  reqData,
    output logic                               rspValid,
    input  logic                               rspReady,
    output logic [ulpiPkg::ulpiDataWidth-1:0]  rspData,
    output logic                               wrStart,
    output logic                               rdStart,
    input  logic                               wrBusy,
    input  logic                               rdBusy,
    input  logic [ulpiPkg::ulpiDataWidth-1:0]  rdByte,
    input  logic                               rdDone,
    output logic [ulpiPkg::ulpiAddrWidth-1:0]  cmdAddr,  // Valid with either start
    output logic [ulpiPkg::ulpiDataWidth-1:0]  cmdData,  // Valid with wrStart
    ulpiBus.link                               wrBus,
    ulpiBus.link                               rdBus,
    output logic [ulpiPkg::ulpiDataWidth-1:0]  dataOut,
    output logic                               stp
);
    logic running;  // Set once out of reset
    logic accept;

    assign accept   = reqValid && reqReady;
    // Idle engines, no start in flight, no response waiting
    assign reqReady = running && !wrBusy && !rdBusy && !wrStart && !rdStart && !rspValid;

    always_ff @(posedge clk_ULPI) begin
        if (accept) begin
            cmdAddr <= reqAddr;
            cmdData <= reqData;
        end
        if (rdDone) rspData <= rdByte;  // Held until handshake
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            running  <= 1'b0;
            wrStart  <= 1'b0;
            rdStart  <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            running <= 1'b1;
            wrStart <= accept && (reqOp == ulpiPkg::REG_WRITE);
            rdStart <= accept && (reqOp == ulpiPkg::REG_READ);
            if (rdDone) rspValid <= 1'b1;
            else if (rspValid && rspReady) rspValid <= 1'b0;
        end
    end

    // Idle engine drives zero
    assign dataOut = wrBus.txData | rdBus.txData;
    assign stp     = wrBus.stp | rdBus.stp;

    assert property (@(posedge clk_ULPI) disable iff (!rst) !(wrBusy && rdBusy))
        else $error("Both register engines active");

endmodule

// File: ULPI/ulpiRegWrite.sv
`timescale 1ns/1ns
// ULPI register-write engine
// TXCMD, data byte and STP under NXT flow control
module ulpiRegWrite (
    input  logic                               clk_ULPI,
    input  logic                               rst,
    input  logic                               start,  // One-cycle pulse from dispatcher
    input  logic [ulpiPkg::ulpiAddrWidth-1:0]  addr,
    input  logic [ulpiPkg::ulpiDataWidth-1:0]  data,
    output logic                               busy,
    ulpiBus.engine                             bus
);
    ulpiPkg::writeStateT                state;
    logic [ulpiPkg::ulpiAddrWidth-1:0]  addrQ;
    logic [ulpiPkg::ulpiDataWidth-1:0]  dataQ;

    // Request payload, valid with start
    always_ff @(posedge clk_ULPI) begin
        if (start && state == ulpiPkg::W_IDLE) begin
            addrQ <= addr;
            dataQ <= data;
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state <= ulpiPkg::W_IDLE;
        end else begin
            case (state)
                ulpiPkg::W_IDLE: if (start) state <= ulpiPkg::W_CMD;
                ulpiPkg::W_CMD: begin
                    if (bus.dir) state <= ulpiPkg::W_IDLE;      // PHY aborted the TXCMD
                    else if (bus.nxt) state <= ulpiPkg::W_DATA; // Command accepted
                end
                ulpiPkg::W_DATA: begin
                    if (bus.dir) state <= ulpiPkg::W_IDLE;
                    else if (bus.nxt) state <= ulpiPkg::W_STOP; // Data accepted
                end
                ulpiPkg::W_STOP: state <= ulpiPkg::W_IDLE;
                default: state <= ulpiPkg::W_IDLE;
            endcase
        end
    end

    assign busy = (state != ulpiPkg::W_IDLE);

    // Outgoing byte is zero outside the command and data phases
    always_comb begin
        bus.txData = '0;
        bus.stp    = 1'b0;
        case (state)
            ulpiPkg::W_CMD:  bus.txData = {ulpiPkg::regWriteCmd, addrQ};
            ulpiPkg::W_DATA: bus.txData = dataQ;
            ulpiPkg::W_STOP: bus.stp = 1'b1;  // Ends the transfer
            default: ;
        endcase
    end

    // STP only closes a transfer the link still owns
    assert property (@(posedge clk_ULPI) disable iff (!rst) bus.stp |-> !bus.dir)
        else $error("STP raised while the PHY owns the bus");

    // DIR during TXCMD means the PHY dropped the command
    assert property (@(posedge clk_ULPI) disable iff (!rst)
        (state == ulpiPkg::W_CMD) |-> !bus.dir)
        else $warning("Register write aborted by PHY turnaround");

endmodule

// File: ULPI/ulpiRegRead.sv
`timescale 1ns/1ns
// ULPI register-read engine
// TXCMD, bus turnaround, capture of the synchronized read byte
module ulpiRegRead (
    input  logic                               clk_ULPI,
    input  logic                               rst,
    input  logic                               start,  // One-cycle pulse from dispatcher
    input  logic [ulpiPkg::ulpiAddrWidth-1:0]  addr,
    output logic                               busy,
    output logic [ulpiPkg::ulpiDataWidth-1:0]  rdByte,
    output logic                               rdDone, // Pulse, rdByte valid
    ulpiBus.engine                             bus
);
    ulpiPkg::readStateT                 state;
    logic [ulpiPkg::ulpiAddrWidth-1:0]  addrQ;
    logic                               capture;

    // First fresh byte after turnaround
    assign capture = (state == ulpiPkg::R_CAPTURE) && bus.rxFresh;

    // Payload registers
    always_ff @(posedge clk_ULPI) begin
        if (start && state == ulpiPkg::R_IDLE) addrQ <= addr;
        if (capture) rdByte <= bus.rxData;
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state  <= ulpiPkg::R_IDLE;
            rdDone <= 1'b0;
        end else begin
            rdDone <= capture;
            case (state)
                ulpiPkg::R_IDLE: if (start) state <= ulpiPkg::R_CMD;
                ulpiPkg::R_CMD: begin
                    if (bus.dir) state <= ulpiPkg::R_IDLE;      // PHY aborted the TXCMD
                    else if (bus.nxt) state <= ulpiPkg::R_TURN; // Command accepted
                end
                // DIR rising is the turnaround cycle
                ulpiPkg::R_TURN: if (bus.dir) state <= ulpiPkg::R_CAPTURE;
                ulpiPkg::R_CAPTURE: if (capture) state <= ulpiPkg::R_RELEASE;
                ulpiPkg::R_RELEASE: if (!bus.dir) state <= ulpiPkg::R_IDLE; // Bus back to link
                default: state <= ulpiPkg::R_IDLE;
            endcase
        end
    end

    assign busy = (state != ulpiPkg::R_IDLE);

    // Link only drives during the command phase
    always_comb begin
        bus.txData = '0;
        if (state == ulpiPkg::R_CMD) begin
            bus.txData = {ulpiPkg::regReadCmd, addrQ};
        end
    end

    assign bus.stp = 1'b0;  // Register read ends by PHY turnaround

    // Captured byte was on the pins with DIR high, syncStages + 1 cycles earlier
    assert property (@(posedge clk_ULPI) disable iff (!rst)
        rdDone |-> $past(bus.dir, ulpiPkg::syncStages + 1))
        else $error("Read byte captured without PHY driving the bus");

    // DIR during TXCMD means the PHY dropped the command
    assert property (@(posedge clk_ULPI) disable iff (!rst)
        (state == ulpiPkg::R_CMD) |-> !bus.dir)
        else $warning("Register read aborted by PHY turnaround");

endmodule

// File: ULPI/ulpiLink.sv
`timescale 1ns/1ns
// ULPI link top with receive synchronizer, PHY reset and bus fan-out
// Instances of request dispatcher, register-write and register-read engines
module ulpiLink (
    input  logic                               clk_ULPI,
    input  logic                               rst,
    // Request channel
    input  logic                               reqValid,
    output logic                               reqReady,
    input  ulpiPkg::regOpT                     reqOp,
    input  logic [ulpiPkg::ulpiAddrWidth-1:0]  reqAddr,
    input  logic [ulpiPkg::ulpiDataWidth-1:0]  reqData,
    // Response channel
    output logic                               rspValid,
    input  logic                               rspReady,
    output logic [ulpiPkg::ulpiDataWidth-1:0]  rspData,
    // PHY pins
    input  logic                               dir,
    input  logic                               nxt,
    input  logic [ulpiPkg::ulpiDataWidth-1:0]  dataIn,
    output logic [ulpiPkg::ulpiDataWidth-1:0]  dataOut,
    output logic                               dataOe,
    output logic                               stp,
    output logic                               phyRst
);
    localparam int stages = ulpiPkg::syncStages;

    logic [ulpiPkg::ulpiDataWidth-1:0]  syncQ [stages];  // Metastability chain
    logic [stages-1:0]                  freshQ;          // Tracks PHY data through syncQ
    logic                               dirQ;
    logic                               wrStart, rdStart, wrBusy, rdBusy, rdDone;
    logic [ulpiPkg::ulpiAddrWidth-1:0]  cmdAddr;
    logic [ulpiPkg::ulpiDataWidth-1:0]  cmdData, rdByte;

    ulpiBus wrBus ();
    ulpiBus rdBus ();

    assign phyRst = !rst;         // PHY held in reset with the link
    assign dataOe = rst && !dir;  // Bus released in reset and while PHY owns it

    // First stage samples the pins only while the PHY drives them
    always_ff @(posedge clk_ULPI) begin
        if (dir) syncQ[0] <= dataIn;
        for (int i = 1; i < stages; i++) begin
            syncQ[i] <= syncQ[i-1];
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            dirQ   <= 1'b0;
            freshQ <= '0;
        end else begin
            dirQ   <= dir;
            freshQ <= {freshQ[stages-2:0], dir && dirQ};  // Turnaround cycle is not data
        end
    end

    // Common receive fields to both engines
    assign wrBus.dir     = dir;
    assign wrBus.nxt     = nxt;
    assign wrBus.rxData  = syncQ[stages-1];
    assign wrBus.rxFresh = freshQ[stages-1];
    assign rdBus.dir     = dir;
    assign rdBus.nxt     = nxt;
    assign rdBus.rxData  = syncQ[stages-1];
    assign rdBus.rxFresh = freshQ[stages-1];

    ulpiReqDispatch dispatch_i (
        .clk_ULPI, .rst,
        .reqValid, .reqReady, .reqOp, .reqAddr, .reqData,
        .rspValid, .rspReady, .rspData,
        .wrStart, .rdStart, .wrBusy, .rdBusy, .rdByte, .rdDone,
        .cmdAddr, .cmdData,
        .wrBus(wrBus.link), .rdBus(rdBus.link),
        .dataOut, .stp
    );

    ulpiRegWrite write_i (
        .clk_ULPI, .rst, .start(wrStart), .addr(cmdAddr), .data(cmdData),
        .busy(wrBusy), .bus(wrBus.engine)
    );

    ulpiRegRead read_i (
        .clk_ULPI, .rst, .start(rdStart), .addr(cmdAddr),
        .busy(rdBusy), .rdByte, .rdDone, .bus(rdBus.engine)
    );

    // Engines have let go of the bus once the turnaround is over
    assert property (@(posedge clk_ULPI) disable iff (!rst)
        (dir && dirQ) |-> (dataOut == '0))
        else $error("Link drives data while the PHY owns the bus");

endmodule

// File: bench/phyModel.sv
`timescale 1ns/1ns
// Behavioural ULPI PHY with register file, random NXT delays and idle DIR pulses
module phyModel (
    input  logic        clk_ULPI,
    input  logic        phyRst,
    input  logic        pulseOk,   // Idle DIR pulses allowed
    input  logic [7:0]  dataOut,
    input  logic        dataOe,
    input  logic        stp,
    output logic        dir,
    output logic        nxt,
    output logic [7:0]  dataIn
);
    typedef enum {
        P_IDLE, P_WCMD, P_WACK, P_WDATA, P_WSTOP,
        P_RCMD, P_RTURN, P_RDATA, P_RBACK, P_PULSE, P_PBACK
    } phyStateT;

    phyStateT    ps;
    logic [7:0]  regs [64];
    logic [7:0]  wrByte;
    logic [5:0]  addr;
    logic [7:0]  busVal;     // Resolved bus
    integer      seed;
    int          delay;

    assign busVal = dataOe ? dataOut : dataIn;

    initial begin
        seed = 32'h8255;
        for (int i = 0; i < 64; i++) regs[i] = 8'(i) ^ 8'h5A;  // Preset pattern
    end

    // Everything changes on the falling edge, away from the link's sampling edge
    always @(negedge clk_ULPI) begin
        if (phyRst) begin
            ps = P_IDLE;
            dir = 1'b0;
            nxt = 1'b0;
            dataIn = 8'h00;
        end else begin
            case (ps)
                P_IDLE: begin
                    if (busVal[7:6] == 2'b10) begin      // Register write TXCMD
                        addr = busVal[5:0];
                        delay = $random(seed) & 3;
                        ps = P_WCMD;
                    end else if (busVal[7:6] == 2'b11) begin  // Register read TXCMD
                        addr = busVal[5:0];
                        delay = $random(seed) & 3;
                        ps = P_RCMD;
                    end else if (pulseOk && ($random(seed) & 3) == 0) begin
                        dir = 1'b1;  // Unsolicited turnaround
                        ps = P_PULSE;
                    end
                end
                P_WCMD: if (delay == 0) begin nxt = 1'b1; ps = P_WACK; end else delay--;
                P_WACK: begin
                    nxt = 1'b0;
                    wrByte = busVal;  // Data byte now on the bus
                    delay = $random(seed) & 3;
                    ps = P_WDATA;
                end
                P_WDATA: if (delay == 0) begin nxt = 1'b1; ps = P_WSTOP; end else delay--;
                P_WSTOP: begin
                    nxt = 1'b0;
                    if (stp) regs[addr] = wrByte;  // Committed on STP
                    ps = P_IDLE;
                end
                P_RCMD: if (delay == 0) begin nxt = 1'b1; ps = P_RTURN; end else delay--;
                P_RTURN: begin nxt = 1'b0; dir = 1'b1; ps = P_RDATA; end
                P_RDATA: begin dataIn = regs[addr]; ps = P_RBACK; end
                P_RBACK: begin dir = 1'b0; dataIn = 8'h00; ps = P_IDLE; end
                P_PULSE: begin dataIn = 8'h0E; ps = P_PBACK; end  // One RX CMD byte
                P_PBACK: begin dir = 1'b0; dataIn = 8'h00; ps = P_IDLE; end
                default: ps = P_IDLE;
            endcase
        end
    end

endmodule

// File: bench/ulpiChecker.sv
`timescale 1ns/1ns
// Checker with shadow register file, response compare and protocol faults
module ulpiChecker (
    input  logic          clk_ULPI,
    input  logic          rst,
    input  logic [95:0]   testName,
    input  logic          reqValid, reqReady, reqOp,
    input  logic [5:0]    reqAddr,
    input  logic [7:0]    reqData,
    input  logic          rspValid, rspReady,
    input  logic [7:0]    rspData,
    input  logic          dir, dataOe, stp, phyRst,
    output int            passCount,
    output int            failCount
);
    logic [7:0]   shadow [64];
    logic [95:0]  nameQ;
    logic [5:0]   rdAddr;
    logic [7:0]   prevData;
    logic         readPending, writePending, prevValid, prevReady, resetDone;
    int           rstCycles;

    initial begin
        for (int i = 0; i < 64; i++) shadow[i] = 8'(i) ^ 8'h5A;
        passCount = 0;
        failCount = 0;
        readPending = 0;
        writePending = 0;
        prevValid = 0;
        prevReady = 0;
        resetDone = 0;
        rstCycles = 0;
    end

    always @(posedge clk_ULPI) begin
        if (!rst) begin
            rstCycles++;
            // First edge only clears the registers
            if (rstCycles > 1 && (reqReady || rspValid || stp || !phyRst || dataOe)) begin
                $display("ERROR: outputs not in their reset state during reset");
                failCount++;
            end
        end else begin
            if (!resetDone) begin
                resetDone = 1;
                if (failCount == 0) begin
                    $display("PASS reset");
                    passCount++;
                end
            end
            if (dataOe && dir) begin
                $display("ERROR: link drives the bus while the PHY owns it");
                failCount++;
            end
            if (rspValid && reqReady) begin
                $display("ERROR: request accepted while a response is waiting");
                failCount++;
            end
            if (prevValid && !prevReady && (!rspValid || rspData != prevData)) begin
                $display("ERROR: response changed before its handshake");
                failCount++;
            end
            if (writePending && reqReady) begin  // Write finished
                $display("PASS %0s", nameQ);
                passCount++;
                writePending = 0;
            end
            if (rspValid && rspReady) begin
                if (!readPending) begin
                    $display("ERROR: response without a read request");
                    failCount++;
                end else if (rspData !== shadow[rdAddr]) begin
                    $display("CHECK FAILED %0s expected %h actual %h",
                             nameQ, shadow[rdAddr], rspData);
                    failCount++;
                end else begin
                    $display("PASS %0s read %h", nameQ, rspData);
                    passCount++;
                end
                readPending = 0;
            end
            if (reqValid && reqReady) begin
                nameQ = testName;
                if (reqOp) begin
                    readPending = 1;
                    rdAddr = reqAddr;
                end else begin
                    shadow[reqAddr] = reqData;  // Mirror of the PHY write
                    writePending = 1;
                end
            end
            prevValid = rspValid;
            prevReady = rspReady;
            prevData = rspData;
        end
    end

endmodule

// File: bench/tbUlpi.sv
`timescale 1ns/1ns
// Testbench top with clock, reset, stimulus table, timeout and instances
module tbUlpi;
    typedef struct packed {
        logic [95:0]  name;
        logic         op;     // 1 for read
        logic [5:0]   addr;
        logic [7:0]   data;
        logic [3:0]   stall;  // rspReady delay
    } stimT;

    localparam int numTests = 14;
    localparam int cycleLimit = 200 * numTests + 10;

    stimT stimTable [numTests] = '{
        '{"rd_untouch0", 1'b1, 6'd0,  8'h00, 4'd0},
        '{"rd_untouch17", 1'b1, 6'd17, 8'h00, 4'd0},
        '{"rd_untouch63", 1'b1, 6'd63, 8'h00, 4'd1},
        '{"wr_0",        1'b0, 6'd0,  8'h3C, 4'd0},
        '{"rd_0",        1'b1, 6'd0,  8'h00, 4'd0},
        '{"wr_63",       1'b0, 6'd63, 8'hA7, 4'd0},
        '{"rd_63",       1'b1, 6'd63, 8'h00, 4'd0},
        '{"wr_21",       1'b0, 6'd21, 8'h0F, 4'd0},
        '{"rd_21_stall", 1'b1, 6'd21, 8'h00, 4'd5},
        '{"wr_42",       1'b0, 6'd42, 8'hC3, 4'd0},
        '{"rd_42_stall", 1'b1, 6'd42, 8'h00, 4'd9},
        '{"rd_9_stall",  1'b1, 6'd9,  8'h00, 4'd2},
        '{"wr_0_again",  1'b0, 6'd0,  8'h55, 4'd0},
        '{"rd_0_again",  1'b1, 6'd0,  8'h00, 4'd3}
    };

    logic            clk_ULPI, rst, reqValid, reqReady, rspValid, rspReady;
    ulpiPkg::regOpT  reqOp;
    logic [5:0]      reqAddr;
    logic [7:0]      reqData, rspData, dataIn, dataOut;
    logic            dir, nxt, dataOe, stp, phyRst, pulseOk;
    logic [95:0]     curName;
    int              passCount, failCount, cycles;

    ulpiLink dut_i (
        .clk_ULPI, .rst, .reqValid, .reqReady, .reqOp, .reqAddr, .reqData,
        .rspValid, .rspReady, .rspData,
        .dir, .nxt, .dataIn, .dataOut, .dataOe, .stp, .phyRst
    );

    phyModel phy_i (
        .clk_ULPI, .phyRst, .pulseOk, .dataOut, .dataOe, .stp, .dir, .nxt, .dataIn
    );

    ulpiChecker chk_i (
        .clk_ULPI, .rst, .testName(curName), .reqValid, .reqReady,
        .reqOp(reqOp == ulpiPkg::REG_READ),
        .reqAddr, .reqData, .rspValid, .rspReady, .rspData,
        .dir, .dataOe, .stp, .phyRst, .passCount, .failCount
    );

    initial begin
        clk_ULPI = 1'b0;
        forever #5 clk_ULPI = ~clk_ULPI;
    end

    // Run limit
    initial cycles = 0;
    always @(posedge clk_ULPI) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b0;
        reqValid = 1'b0;
        reqOp = ulpiPkg::REG_WRITE;
        reqAddr = '0;
        reqData = '0;
        rspReady = 1'b0;
        pulseOk = 1'b0;
        curName = '0;
        repeat (10) @(posedge clk_ULPI);
        @(negedge clk_ULPI) rst = 1'b1;
        for (int i = 0; i < numTests; i++) begin
            // Window for idle DIR pulses, then let any pulse finish
            @(negedge clk_ULPI) pulseOk <= 1'b1;
            repeat (8) @(negedge clk_ULPI);
            pulseOk <= 1'b0;
            repeat (4) @(negedge clk_ULPI);
            while (!reqReady) @(negedge clk_ULPI);
            curName = stimTable[i].name;
            reqOp = ulpiPkg::regOpT'(stimTable[i].op);
            reqAddr = stimTable[i].addr;
            reqData = stimTable[i].data;
            reqValid = 1'b1;
            @(negedge clk_ULPI) reqValid = 1'b0;  // Accepted on the edge just passed
            if (stimTable[i].op) begin
                while (!rspValid) @(negedge clk_ULPI);
                repeat (stimTable[i].stall) @(negedge clk_ULPI);
                rspReady = 1'b1;
                @(negedge clk_ULPI) rspReady = 1'b0;
            end else begin
                @(negedge clk_ULPI);
                while (!reqReady) @(negedge clk_ULPI);
            end
        end
        repeat (3) @(negedge clk_ULPI);
        $display("Tests passed: %0d failed: %0d", passCount, failCount);
        if (failCount == 0 && passCount == numTests + 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: files.f
common/ulpiPkg.sv
common/ulpiBus.sv
verilog/ulpiReqDispatch.sv
ULPI/ulpiRegWrite.sv
ULPI/ulpiRegRead.sv
ULPI/ulpiLink.sv
bench/phyModel.sv
bench/ulpiChecker.sv
bench/tbUlpi.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ULPI link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbUlpi -f files.f -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1
